// ==== source/kbd_bridge_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// kbd_bridge shared definitions
// scan code type, reset hold, FIFO sizing,
// PS/2 framing and UART baud constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package kbd_bridge_pkg;

	// one received scan code
	typedef logic [7:0] scan_byte_t;

	// reset sequencer
	localparam int reset_count_width = 16;	// sanity counter width
	localparam logic [reset_count_width-1:0] reset_hold_cycles = 16'd64;	// clocks after reset2a

	// scan code FIFO
	localparam int fifo_depth     = 8;	// entries
	localparam int fifo_ptr_width = 3;	// log2 of depth, count is one wider

	// one slot kept back for a frame that is already on the wire
	localparam int almost_full_level = fifo_depth - 1;

	// PS/2 framing, start + 8 data + parity + stop
	localparam int ps2_frame_bits = 11;

	// longest gap between two PS/2 clock edges inside a frame
	localparam int frame_timeout_cycles = 4096;	// about 82 us at 50 MHz

	// UART 8N1
	localparam int uart_clocks_per_bit = 434;	// 50 MHz / 434, roughly 115200 baud
	localparam int uart_frame_bits     = 10;	// start + 8 data + stop

	// note: the baud error at 434 is well under one percent,
	// so no fractional divider is needed

endpackage

// ==== source/pad_ring.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pad_ring
// open-drain PS/2 clock drive and two-flop
// synchronizers for both PS/2 lines
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module pad_ring (
	input  logic clock_50mhz,
	input  logic reset2a,
	inout  wire  ps2_clk_io,
	inout  wire  ps2_data_io,	// input only, host-to-device not supported
	input  logic ps2_clk_hold_i,	// high pulls the keyboard clock low
	output logic ps2_clk_sync_o,
	output logic ps2_data_sync_o
);

	logic [1:0] pad_in;	// {clk, data} straight off the pads
	logic [1:0] meta_q;	// first stage, may go metastable
	logic [1:0] sync_q;	// second stage, safe to use

	// open drain, only ever pull low, the pull-up gives the high level
	assign ps2_clk_io = ps2_clk_hold_i ? 1'b0 : 1'bz;

	// read back both pads, the clock pad sees our own hold too
	assign pad_in = {ps2_clk_io, ps2_data_io};

	// both lines idle high, so the synchronizers come out of reset at 1
	always_ff @(posedge clock_50mhz)
	begin
		if (reset2a)
		begin
			meta_q <= 2'b11;
			sync_q <= 2'b11;
		end
		else
		begin
			meta_q <= pad_in;	// async keyboard lines land here
			sync_q <= meta_q;
		end
	end

	// pad to output takes two clocks
	assign ps2_clk_sync_o  = sync_q[1];
	assign ps2_data_sync_o = sync_q[0];

endmodule

// ==== source/reset_sequencer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reset_sequencer
// holds the core in reset for a fixed count
// after reset2a, then raises system ready
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module reset_sequencer (
	input  logic clock_50mhz,
	input  logic reset2a,
	output logic core_reset_o,
	output logic system_ready_o
);

	logic [kbd_bridge_pkg::reset_count_width-1:0] hold_count_q;
	logic hold_done;

	assign hold_done = (hold_count_q == kbd_bridge_pkg::reset_hold_cycles);

	always_ff @(posedge clock_50mhz)
	begin
		if (reset2a)
		begin
			hold_count_q   <= '0;	// restart the hold on every reset2a
			core_reset_o   <= 1'b1;
			system_ready_o <= 1'b0;
		end
		else
		begin
			if (!hold_done)
				hold_count_q <= hold_count_q + 1'b1;	// saturates at the hold count
			// both flags come off the same count, so they swap in one cycle
			core_reset_o   <= !hold_done;
			system_ready_o <= hold_done;
		end
	end

	// core logic never sees ready while it is still held in reset
	assert property (@(posedge clock_50mhz) disable iff (reset2a)
		!(system_ready_o && core_reset_o));

endmodule

// ==== source/ps2_frame_receiver.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ps2_frame_receiver
// samples PS/2 frames on falling clock edges,
// checks framing and odd parity, writes good
// scan codes and inhibits the clock when full
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module ps2_frame_receiver (
	input  logic clock_50mhz,
	input  logic core_reset_i,
	input  logic ps2_clk_sync_i,
	input  logic ps2_data_sync_i,
	input  logic fifo_almost_full_i,
	output logic ps2_clk_hold_o,
	output logic fifo_write_o,
	output kbd_bridge_pkg::scan_byte_t fifo_write_data_o,
	output logic frame_error_o
);

	localparam int last_index = kbd_bridge_pkg::ps2_frame_bits - 1;

	logic clk_prev_q;	// last synced clock, for edge detect
	logic clk_fall;
	logic receiving_q;	// inside a frame
	logic [3:0] bit_count_q;	// bits taken so far
	logic [last_index:0] shift_q;	// new bits enter at the top
	logic [last_index:0] shift_next;
	logic [$clog2(kbd_bridge_pkg::frame_timeout_cycles):0] timer_q;	// clocks since last edge
	logic last_bit;
	logic frame_good;

	// our own hold also pulls the clock low, that edge is not the keyboard
	assign clk_fall = clk_prev_q & ~ps2_clk_sync_i & ~ps2_clk_hold_o;

	// LSB first on the wire, so after 11 shifts the start bit sits in bit 0
	assign shift_next = {ps2_data_sync_i, shift_q[last_index:1]};
	assign last_bit   = (bit_count_q == last_index);

	// start 0, stop 1, data plus parity has an odd number of ones
	assign frame_good = ~shift_next[0] & shift_next[last_index]
		& (^shift_next[last_index-1:1]);

	always_ff @(posedge clock_50mhz)
	begin
		if (core_reset_i)
			clk_prev_q <= 1'b1;	// bus idles high
		else
			clk_prev_q <= ps2_clk_sync_i;
	end

	// frame control
	always_ff @(posedge clock_50mhz)
	begin
		if (core_reset_i)
		begin
			receiving_q    <= 1'b0;
			bit_count_q    <= '0;
			timer_q        <= '0;
			ps2_clk_hold_o <= 1'b0;
			fifo_write_o   <= 1'b0;
			frame_error_o  <= 1'b0;
		end
		else
		begin
			fifo_write_o  <= 1'b0;	// both strobes last one cycle
			frame_error_o <= 1'b0;
			if (!receiving_q)
			begin
				timer_q <= '0;
				if (clk_fall && !ps2_data_sync_i)
				begin
					receiving_q    <= 1'b1;	// valid start bit
					bit_count_q    <= 4'd1;
					ps2_clk_hold_o <= 1'b0;
				end
				else
					ps2_clk_hold_o <= fifo_almost_full_i;	// inhibit only between frames
				// a fall with data high is a glitch, not a start, and is dropped
			end
			else if (clk_fall)
			begin
				timer_q     <= '0;
				bit_count_q <= bit_count_q + 1'b1;
				if (last_bit)
				begin
					receiving_q   <= 1'b0;	// stop bit taken
					fifo_write_o  <= frame_good;
					frame_error_o <= !frame_good;
				end
			end
			else if (timer_q == kbd_bridge_pkg::frame_timeout_cycles)
				receiving_q <= 1'b0;	// keyboard stalled, drop the partial frame
			else
				timer_q <= timer_q + 1'b1;
		end
	end

	// payload side
	always_ff @(posedge clock_50mhz)
	begin
		if (clk_fall)
			shift_q <= shift_next;
		if (clk_fall && receiving_q && last_bit)
			fifo_write_data_o <= shift_next[8:1];	// data bits between start and parity
	end

	// hold may only start once the previous frame is finished
	assert property (@(posedge clock_50mhz) disable iff (core_reset_i)
		$rose(ps2_clk_hold_o) |-> !$past(receiving_q));

endmodule

// ==== source/scan_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scan_fifo
// first-word-fall-through circular buffer of
// scan codes with full and almost-full flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module scan_fifo (
	input  logic clock_50mhz,
	input  logic core_reset_i,
	input  logic write_i,
	input  kbd_bridge_pkg::scan_byte_t write_data_i,
	input  logic read_i,
	output kbd_bridge_pkg::scan_byte_t read_data_o,
	output logic empty_o,
	output logic full_o,
	output logic almost_full_o
);

	kbd_bridge_pkg::scan_byte_t mem_q [kbd_bridge_pkg::fifo_depth];

	logic [kbd_bridge_pkg::fifo_ptr_width-1:0] wr_ptr_q;	// next free slot
	logic [kbd_bridge_pkg::fifo_ptr_width-1:0] rd_ptr_q;	// oldest entry
	logic [kbd_bridge_pkg::fifo_ptr_width:0]   count_q;	// one wider to reach depth

	// pointers wrap on their own since depth is a power of two
	always_ff @(posedge clock_50mhz)
	begin
		if (core_reset_i)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end
		else
		begin
			if (write_i)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (read_i)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			case ({write_i, read_i})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;	// none, or both in the same cycle
			endcase
		end
	end

	always_ff @(posedge clock_50mhz)
	begin
		if (write_i)
			mem_q[wr_ptr_q] <= write_data_i;
	end

	assign read_data_o   = mem_q[rd_ptr_q];	// head is always on the output
	assign empty_o       = (count_q == 0);
	assign full_o        = (count_q == kbd_bridge_pkg::fifo_depth);
	assign almost_full_o = (count_q >= kbd_bridge_pkg::almost_full_level);

	// the receiver backs off at almost-full, so it must never hit full
	assert property (@(posedge clock_50mhz) disable iff (core_reset_i)
		write_i |-> !full_o);

	assert property (@(posedge clock_50mhz) disable iff (core_reset_i)
		read_i |-> !empty_o);

endmodule

// ==== source/uart_byte_transmitter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart_byte_transmitter
// pops scan codes from the FIFO and sends them
// as 8N1 frames at a fixed baud divider
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module uart_byte_transmitter (
	input  logic clock_50mhz,
	input  logic core_reset_i,
	input  logic fifo_empty_i,
	input  kbd_bridge_pkg::scan_byte_t fifo_data_i,
	output logic fifo_read_o,
	output logic uart_txd_o
);

	logic busy_q;	// a frame is on the line
	logic [$clog2(kbd_bridge_pkg::uart_clocks_per_bit)-1:0] baud_q;	// clocks into this bit
	logic [3:0] bit_count_q;	// 0 is the start bit
	logic [8:0] shift_q;	// {stop, data}, next bit in bit 0
	logic baud_tick;
	logic frame_end;

	assign baud_tick = (baud_q == kbd_bridge_pkg::uart_clocks_per_bit - 1);
	assign frame_end = (bit_count_q == kbd_bridge_pkg::uart_frame_bits - 1);

	always_ff @(posedge clock_50mhz)
	begin
		if (core_reset_i)
		begin
			busy_q      <= 1'b0;
			baud_q      <= '0;
			bit_count_q <= '0;
			fifo_read_o <= 1'b0;
			uart_txd_o  <= 1'b1;	// line idles high
		end
		else
		begin
			fifo_read_o <= 1'b0;
			if (!busy_q)
			begin
				if (!fifo_empty_i)
				begin
					busy_q      <= 1'b1;
					baud_q      <= '0;
					bit_count_q <= '0;
					fifo_read_o <= 1'b1;	// pop lands in the start bit cycle
					uart_txd_o  <= 1'b0;	// start bit
				end
			end
			else if (baud_tick)
			begin
				baud_q <= '0;
				if (frame_end)
				begin
					busy_q     <= 1'b0;	// stop bit done, back to idle
					uart_txd_o <= 1'b1;
				end
				else
				begin
					bit_count_q <= bit_count_q + 1'b1;
					uart_txd_o  <= shift_q[0];
				end
			end
			else
				baud_q <= baud_q + 1'b1;
		end
	end

	// byte shifter, loaded from the FIFO head while idle
	always_ff @(posedge clock_50mhz)
	begin
		if (!busy_q)
			shift_q <= {1'b1, fifo_data_i};	// stop bit rides above the data
		else if (baud_tick)
			shift_q <= {1'b1, shift_q[8:1]};
	end

	// each pop belongs to exactly one frame start out of idle
	assert property (@(posedge clock_50mhz) disable iff (core_reset_i)
		fifo_read_o |-> !$past(busy_q));

endmodule

// ==== source/kbd_bridge_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// kbd_bridge_top
// board top level, PS/2 keyboard in through
// a scan code FIFO and out on the UART
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module kbd_bridge_top (
	input  logic clock_50mhz,
	input  logic reset2a,	// board reset, active high
	inout  wire  ps2_clk_io,	// open drain, pulled up on the board
	inout  wire  ps2_data_io,
	output logic uart_txd_o,
	output logic system_ready_o,
	output logic frame_error_o	// one pulse per bad frame
);

	logic ps2_clk_sync;
	logic ps2_data_sync;
	logic ps2_clk_hold;	// inhibit request back to the pad
	logic core_reset;

	logic fifo_write;
	kbd_bridge_pkg::scan_byte_t fifo_write_data;
	logic fifo_almost_full;
	logic fifo_read;
	kbd_bridge_pkg::scan_byte_t fifo_read_data;
	logic fifo_empty;

	pad_ring pad_ring_i (
		.clock_50mhz     (clock_50mhz),
		.reset2a         (reset2a),	// pads run off board reset, not core reset
		.ps2_clk_io      (ps2_clk_io),
		.ps2_data_io     (ps2_data_io),
		.ps2_clk_hold_i  (ps2_clk_hold),
		.ps2_clk_sync_o  (ps2_clk_sync),
		.ps2_data_sync_o (ps2_data_sync)
	);

	reset_sequencer reset_sequencer_i (
		.clock_50mhz    (clock_50mhz),
		.reset2a        (reset2a),
		.core_reset_o   (core_reset),
		.system_ready_o (system_ready_o)
	);

	// producer
	ps2_frame_receiver ps2_frame_receiver_i (
		.clock_50mhz        (clock_50mhz),
		.core_reset_i       (core_reset),
		.ps2_clk_sync_i     (ps2_clk_sync),
		.ps2_data_sync_i    (ps2_data_sync),
		.fifo_almost_full_i (fifo_almost_full),
		.ps2_clk_hold_o     (ps2_clk_hold),
		.fifo_write_o       (fifo_write),
		.fifo_write_data_o  (fifo_write_data),
		.frame_error_o      (frame_error_o)
	);

	scan_fifo scan_fifo_i (
		.clock_50mhz   (clock_50mhz),
		.core_reset_i  (core_reset),
		.write_i       (fifo_write),
		.write_data_i  (fifo_write_data),
		.read_i        (fifo_read),
		.read_data_o   (fifo_read_data),
		.empty_o       (fifo_empty),
		.full_o        (),	// only watched by the FIFO's own check
		.almost_full_o (fifo_almost_full)
	);

	// consumer
	uart_byte_transmitter uart_byte_transmitter_i (
		.clock_50mhz  (clock_50mhz),
		.core_reset_i (core_reset),
		.fifo_empty_i (fifo_empty),
		.fifo_data_i  (fifo_read_data),
		.fifo_read_o  (fifo_read),
		.uart_txd_o   (uart_txd_o)
	);

endmodule

// ==== dv/kbd_bridge_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// kbd_bridge testbench
// PS/2 keyboard model, UART monitor and a
// scan code table run against the bridge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module kbd_bridge_tb;

	localparam int drive_delay     = 2;	// ns after the rising edge
	localparam int ps2_half_cycles = 50;	// 1 us half period, 22 us per frame
	localparam int bit_cycles      = kbd_bridge_pkg::uart_clocks_per_bit;
	localparam int byte_cycles     = kbd_bridge_pkg::uart_frame_bits * bit_cycles;
	localparam int row_count       = 16;

	logic clock_50mhz = 1'b0;
	logic reset2a;
	logic dev_clk_low;	// keyboard pulls its clock low
	logic dev_data_low;
	logic uart_txd;
	logic system_ready;
	logic frame_error;

	wire ps2_clk_net;
	wire ps2_data_net;

	integer seed;
	int error_count;
	int timeout_count;
	int holds_seen;	// frames that had to wait for an inhibit
	int bytes_received;
	int flagged_rows;
	int ready_cycles;
	int error_pulses = 0;

	logic [8:0] stim_table [0:row_count-1];	// {corrupt parity, scan code}
	logic [7:0] expected_bytes [$];

	// board pull-ups with open-drain drivers on the keyboard side
	pullup (ps2_clk_net);
	pullup (ps2_data_net);
	assign ps2_clk_net  = dev_clk_low ? 1'b0 : 1'bz;
	assign ps2_data_net = dev_data_low ? 1'b0 : 1'bz;

	kbd_bridge_top kbd_bridge_top_i (
		.clock_50mhz    (clock_50mhz),
		.reset2a        (reset2a),
		.ps2_clk_io     (ps2_clk_net),
		.ps2_data_io    (ps2_data_net),
		.uart_txd_o     (uart_txd),
		.system_ready_o (system_ready),
		.frame_error_o  (frame_error)
	);

	always #10 clock_50mhz = ~clock_50mhz;	// 50 MHz

	// pulse is one cycle wide, so each one is seen at exactly one edge
	always @(negedge clock_50mhz)
		if (frame_error === 1'b1)
			error_pulses <= error_pulses + 1;

	task check_value(input string name, input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("FAILED at %0t ns: %s expected 0x%0h, actual 0x%0h",
				$time, name, expected, actual);
			error_count++;
		end
	endtask

	task finish_run;
		$display("errors %0d, timeouts %0d, uart bytes %0d, frame error pulses %0d, holds %0d",
			error_count, timeout_count, bytes_received, error_pulses, holds_seen);
		if (error_count == 0 && timeout_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	endtask

	task report_timeout(input string what);
		$display("ERROR at %0t ns: timed out %s", $time, what);
		timeout_count++;
		finish_run;
	endtask

	// one PS/2 half period that ends just after a rising edge
	task wait_half_period;
		repeat (ps2_half_cycles) @(posedge clock_50mhz);
		#drive_delay;
	endtask

	task load_table;
		stim_table[0]  = {1'b0, 8'h1c};
		stim_table[1]  = {1'b0, 8'h32};
		stim_table[2]  = {1'b0, 8'h21};
		stim_table[3]  = {1'b1, 8'h23};	// bad parity
		stim_table[4]  = {1'b0, 8'h24};
		stim_table[5]  = {1'b0, 8'h2b};
		stim_table[6]  = {1'b0, 8'h34};
		stim_table[7]  = {1'b0, 8'h33};
		stim_table[8]  = {1'b0, 8'h43};
		stim_table[9]  = {1'b1, 8'h3b};	// bad parity
		stim_table[10] = {1'b0, 8'h42};
		stim_table[11] = {1'b0, 8'h4b};
		stim_table[12] = {1'b0, 8'h3a};
		stim_table[13] = {1'b0, 8'h31};
		stim_table[14] = {1'b1, 8'h44};	// bad parity
		stim_table[15] = {1'b0, 8'h4d};
	endtask

	// the host may hold the clock low to inhibit the keyboard
	task wait_clock_release;
		int waited;
		waited = 0;
		while (ps2_clk_net !== 1'b1)
		begin
			@(posedge clock_50mhz);
			#drive_delay;
			waited++;
			if (waited > 4 * byte_cycles)
				report_timeout("waiting for the PS/2 clock to be released");
		end
		if (waited > 0)
			holds_seen++;
	endtask

	task send_ps2_frame(input logic [7:0] code, input logic corrupt);
		logic [10:0] frame_bits;
		int i;
		// stop, odd parity, data and start with bit 0 sent first
		frame_bits = {1'b1, (~^code) ^ corrupt, code, 1'b0};
		for (i = 0; i < kbd_bridge_pkg::ps2_frame_bits; i++)
		begin
			dev_data_low = ~frame_bits[i];	// data set up while clock is high
			wait_half_period;
			dev_clk_low = 1'b1;	// host samples on this fall
			wait_half_period;
			dev_clk_low = 1'b0;
		end
		dev_data_low = 1'b0;
	endtask

	task send_table;
		int row;
		int gap;
		for (row = 0; row < row_count; row++)
		begin
			@(posedge clock_50mhz);
			#drive_delay;
			wait_clock_release;
			gap = 1 + ({$random(seed)} % 32);	// short random gap between frames
			repeat (gap) @(posedge clock_50mhz);
			#drive_delay;
			send_ps2_frame(stim_table[row][7:0], stim_table[row][8]);
		end
	endtask

	// samples every bit at its centre after a falling start edge
	task receive_uart_bytes;
		int idx;
		int bit_idx;
		int waited;
		logic [7:0] rx_byte;
		for (idx = 0; idx < expected_bytes.size(); idx++)
		begin
			waited = 0;
			@(negedge clock_50mhz);
			while (uart_txd !== 1'b0)
			begin
				waited++;
				if (waited > 4 * byte_cycles)
					report_timeout("waiting for a UART start bit");
				@(negedge clock_50mhz);
			end
			repeat (bit_cycles / 2) @(negedge clock_50mhz);
			check_value("uart_txd_o start bit", 0, uart_txd);
			for (bit_idx = 0; bit_idx < 8; bit_idx++)
			begin
				repeat (bit_cycles) @(negedge clock_50mhz);
				rx_byte[bit_idx] = uart_txd;	// LSB first
			end
			repeat (bit_cycles) @(negedge clock_50mhz);
			check_value("uart_txd_o stop bit", 1, uart_txd);
			check_value("uart_txd_o byte", expected_bytes[idx], rx_byte);
			bytes_received++;
		end
	endtask

	initial
	begin
		int i;
		int low_samples;
		seed           = 32'hacaf84ea;
		reset2a        = 1'b1;
		dev_clk_low    = 1'b0;
		dev_data_low   = 1'b0;
		error_count    = 0;
		timeout_count  = 0;
		holds_seen     = 0;
		bytes_received = 0;
		flagged_rows   = 0;
		load_table;
		// good rows come out on the UART in order while bad ones only pulse an error
		for (i = 0; i < row_count; i++)
			if (stim_table[i][8])
				flagged_rows++;
			else
				expected_bytes.push_back(stim_table[i][7:0]);

		repeat (16) @(posedge clock_50mhz);
		#1;
		check_value("system_ready_o in reset", 0, system_ready);
		check_value("uart_txd_o in reset", 1, uart_txd);
		#1 reset2a = 1'b0;

		// one edge to sample reset2a low and then the hold count
		ready_cycles = 0;
		while (system_ready !== 1'b1)
		begin
			check_value("uart_txd_o during hold", 1, uart_txd);
			@(posedge clock_50mhz);
			#1;
			ready_cycles++;
			if (ready_cycles > 4 * kbd_bridge_pkg::reset_hold_cycles)
				report_timeout("waiting for system_ready_o");
		end
		check_value("system_ready_o delay", kbd_bridge_pkg::reset_hold_cycles + 1, ready_cycles);

		fork
			send_table;
			receive_uart_bytes;
		join

		// line must stay idle with nothing beyond the expected list
		low_samples = 0;
		repeat (2 * byte_cycles)
		begin
			@(negedge clock_50mhz);
			if (uart_txd !== 1'b1)
				low_samples++;
		end
		check_value("uart_txd_o low samples after burst", 0, low_samples);
		check_value("frame_error_o pulses", flagged_rows, error_pulses);
		check_value("ps2 clock hold seen", 1, holds_seen > 0);
		finish_run;
	end

endmodule

// ==== kbd_bridge.f ====
source/kbd_bridge_pkg.sv
source/pad_ring.sv
source/reset_sequencer.sv
source/ps2_frame_receiver.sv
source/scan_fifo.sv
source/uart_byte_transmitter.sv
source/kbd_bridge_top.sv
dv/kbd_bridge_tb.sv
